/* verilog/board_bus_pkg.sv */
// shared widths, region codes, register indices and watchdog constants for the board bus hub
package board_bus_pkg;

    // -------------------- bus widths
    localparam int addr_w        = 16;   // register address
    localparam int data_w        = 32;   // register data
    localparam int bw_addr_w     = 8;    // block-write address, zero-extended
    localparam int rt_addr_w     = 4;    // real-time write address
    localparam int sample_addr_w = 6;    // sample buffer address
    localparam int region_w      = 4;    // addr[15:12]
    localparam int reg_idx_w     = 4;    // addr[3:0] inside main block
    localparam int board_id_w    = 4;    // rotary switch

    // -------------------- region codes
    localparam logic [region_w-1:0] addr_main = 4'd0;
    localparam logic [region_w-1:0] addr_hub  = 4'd2;
    localparam logic [region_w-1:0] addr_prom = 4'd3;
    localparam logic [region_w-1:0] addr_fw   = 4'd5;

    // region select bit positions
    localparam int region_count = 5;
    localparam int sel_main     = 0;
    localparam int sel_hub      = 1;
    localparam int sel_prom     = 2;
    localparam int sel_fw       = 3;
    localparam int sel_ext      = 4;

    // -------------------- main register indices
    localparam logic [reg_idx_w-1:0] reg_status = 4'd0;
    localparam logic [reg_idx_w-1:0] reg_wdog   = 4'd3;
    localparam logic [reg_idx_w-1:0] reg_ipaddr = 4'd11;

    localparam logic [data_w-1:0] ip_reset_value = '1;   // unassigned address

    // -------------------- watchdog
    localparam int wdog_period_w    = 16;
    localparam int wdog_tick_cycles = 16;   // sysclk cycles per period unit
    localparam int wdog_count_w     = wdog_period_w + $clog2(wdog_tick_cycles);

endpackage

/* verilog/host_bus_arbiter.sv */
// execute stage of the hub: fixed-priority selection of write, read, real-time and sample sources
`timescale 1ns/1ps

module host_bus_arbiter (
    // block-write engine
    input  logic                                      bw_write_en,
    input  logic                                      bw_reg_wen,
    input  logic                                      bw_blk_wen,
    input  logic                                      bw_blk_wstart,
    input  logic [board_bus_pkg::bw_addr_w-1:0]       bw_reg_waddr,
    input  logic [board_bus_pkg::data_w-1:0]          bw_reg_wdata,
    // ethernet host
    input  logic                                      eth_write_en,
    input  logic                                      eth_reg_wen,
    input  logic                                      eth_blk_wen,
    input  logic                                      eth_blk_wstart,
    input  logic [board_bus_pkg::addr_w-1:0]          eth_reg_waddr,
    input  logic [board_bus_pkg::data_w-1:0]          eth_reg_wdata,
    input  logic                                      eth_req_read_bus,
    input  logic [board_bus_pkg::addr_w-1:0]          eth_reg_raddr,
    input  logic                                      eth_rt_wen,
    input  logic [board_bus_pkg::rt_addr_w-1:0]       eth_rt_waddr,
    input  logic [board_bus_pkg::data_w-1:0]          eth_rt_wdata,
    input  logic                                      eth_sample_start,
    input  logic                                      eth_sample_read,
    input  logic [board_bus_pkg::sample_addr_w-1:0]   eth_sample_raddr,
    // firewire host, default owner of every bus
    input  logic                                      fw_reg_wen,
    input  logic                                      fw_blk_wen,
    input  logic                                      fw_blk_wstart,
    input  logic [board_bus_pkg::addr_w-1:0]          fw_reg_waddr,
    input  logic [board_bus_pkg::data_w-1:0]          fw_reg_wdata,
    input  logic [board_bus_pkg::addr_w-1:0]          fw_reg_raddr,
    input  logic                                      fw_rt_wen,
    input  logic [board_bus_pkg::rt_addr_w-1:0]       fw_rt_waddr,
    input  logic [board_bus_pkg::data_w-1:0]          fw_rt_wdata,
    input  logic                                      fw_sample_start,
    input  logic                                      fw_sample_read,
    input  logic [board_bus_pkg::sample_addr_w-1:0]   fw_sample_raddr,
    input  logic                                      sample_busy,       // sampler running
    // arbitrated buses
    output logic                                      reg_wen,
    output logic                                      blk_wen,
    output logic                                      blk_wstart,
    output logic [board_bus_pkg::addr_w-1:0]          reg_waddr,
    output logic [board_bus_pkg::data_w-1:0]          reg_wdata,
    output logic [board_bus_pkg::addr_w-1:0]          reg_raddr,
    output logic                                      rt_wen,
    output logic [board_bus_pkg::rt_addr_w-1:0]       rt_waddr,
    output logic [board_bus_pkg::data_w-1:0]          rt_wdata,
    output logic                                      sample_start,
    output logic                                      sample_read,
    output logic [board_bus_pkg::sample_addr_w-1:0]   sample_raddr
);

    // -------------------- write bus
    always_comb begin
        if (bw_write_en) begin                     // real-time block write wins
            reg_wen    = bw_reg_wen;
            blk_wen    = bw_blk_wen;
            blk_wstart = bw_blk_wstart;
            reg_waddr  = {{(board_bus_pkg::addr_w-board_bus_pkg::bw_addr_w){1'b0}}, bw_reg_waddr};
            reg_wdata  = bw_reg_wdata;
        end else if (eth_write_en) begin           // then ethernet
            reg_wen    = eth_reg_wen;
            blk_wen    = eth_blk_wen;
            blk_wstart = eth_blk_wstart;
            reg_waddr  = eth_reg_waddr;
            reg_wdata  = eth_reg_wdata;
        end else begin                             // firewire by default
            reg_wen    = fw_reg_wen;
            blk_wen    = fw_blk_wen;
            blk_wstart = fw_blk_wstart;
            reg_waddr  = fw_reg_waddr;
            reg_wdata  = fw_reg_wdata;
        end
    end

    // -------------------- read address and real-time port
    assign reg_raddr = eth_req_read_bus ? eth_reg_raddr : fw_reg_raddr;

    assign rt_wen   = eth_rt_wen ? eth_rt_wen   : fw_rt_wen;
    assign rt_waddr = eth_rt_wen ? eth_rt_waddr : fw_rt_waddr;
    assign rt_wdata = eth_rt_wen ? eth_rt_wdata : fw_rt_wdata;

    // -------------------- sampling
    // only one host is expected to be active at a time
    assign sample_start = (eth_sample_start | fw_sample_start) & ~sample_busy;
    assign sample_read  = eth_sample_read | fw_sample_read;
    assign sample_raddr = eth_sample_read ? eth_sample_raddr : fw_sample_raddr;

endmodule

/* verilog/reg_addr_decode.sv */
// decode stage of the hub: read address to one-hot region select, write address to register strobes
`timescale 1ns/1ps

module reg_addr_decode (
    input  logic [board_bus_pkg::addr_w-1:0]        reg_raddr,
    input  logic [board_bus_pkg::addr_w-1:0]        reg_waddr,
    input  logic                                    reg_wen,
    output logic [board_bus_pkg::region_count-1:0]  region_sel,   // one-hot
    output logic                                    ip_wen,
    output logic                                    wdog_wen
);

    localparam int mid_w = board_bus_pkg::addr_w - board_bus_pkg::region_w
                           - board_bus_pkg::reg_idx_w;            // addr[11:4]

    logic [board_bus_pkg::region_w-1:0] region;
    logic                               is_main;

    assign region  = reg_raddr[board_bus_pkg::addr_w-1 -: board_bus_pkg::region_w];
    // main block only covers addr[7:4] == 0
    assign is_main = (region == board_bus_pkg::addr_main) && (reg_raddr[7:4] == 4'd0);

    always_comb begin
        region_sel = '0;
        if (is_main)
            region_sel[board_bus_pkg::sel_main] = 1'b1;
        else if (region == board_bus_pkg::addr_hub)
            region_sel[board_bus_pkg::sel_hub] = 1'b1;
        else if (region == board_bus_pkg::addr_prom)
            region_sel[board_bus_pkg::sel_prom] = 1'b1;
        else if (region == board_bus_pkg::addr_fw)
            region_sel[board_bus_pkg::sel_fw] = 1'b1;
        else
            region_sel[board_bus_pkg::sel_ext] = 1'b1;   // board side and unmapped
    end

    // -------------------- write strobes, exact address only
    assign ip_wen   = reg_wen && (reg_waddr == {board_bus_pkg::addr_main, {mid_w{1'b0}},
                                                board_bus_pkg::reg_ipaddr});
    assign wdog_wen = reg_wen && (reg_waddr == {board_bus_pkg::addr_main, {mid_w{1'b0}},
                                                board_bus_pkg::reg_wdog});

endmodule

/* verilog/board_regs.sv */
// board-register channel: status, IP address and watchdog period with its timeout counter
`timescale 1ns/1ps

module board_regs (
    input  logic                                    sysclk,
    input  logic                                    rst_n,
    input  logic [board_bus_pkg::board_id_w-1:0]    board_id,
    input  logic [board_bus_pkg::reg_idx_w-1:0]     reg_raddr,     // index bits of read address
    input  logic [board_bus_pkg::data_w-1:0]        reg_wdata,
    input  logic                                    reg_wen,       // any bus write, kicks watchdog
    input  logic                                    ip_wen,
    input  logic                                    wdog_wen,
    input  logic                                    wdog_clear,
    output logic [board_bus_pkg::data_w-1:0]        main_rdata,
    output logic                                    main_hit,
    output logic                                    wdog_timeout,
    output logic [board_bus_pkg::data_w-1:0]        ip_address
);

    logic [board_bus_pkg::wdog_period_w-1:0] wdog_period;   // in units of tick cycles
    logic [board_bus_pkg::wdog_count_w-1:0]  wdog_count;    // sysclk cycles since last write
    logic [board_bus_pkg::wdog_count_w-1:0]  wdog_limit;
    logic [board_bus_pkg::wdog_count_w-1:0]  wdog_next;

    assign wdog_limit = board_bus_pkg::wdog_count_w'(wdog_period)
                        * board_bus_pkg::wdog_count_w'(board_bus_pkg::wdog_tick_cycles);
    assign wdog_next  = wdog_count + 1'b1;

    // -------------------- IP address and period
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            ip_address  <= board_bus_pkg::ip_reset_value;
            wdog_period <= '0;                                       // watchdog off
        end else begin
            if (ip_wen)
                ip_address <= reg_wdata;
            if (wdog_wen)
                wdog_period <= reg_wdata[board_bus_pkg::wdog_period_w-1:0];
        end
    end

    // -------------------- watchdog
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else if (wdog_clear || wdog_wen) begin                  // flag and count restart
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else if (reg_wen || (wdog_period == '0)) begin
            wdog_count   <= '0;                                      // host alive or disabled
        end else if (!wdog_timeout) begin
            wdog_count <= wdog_next;
            if (wdog_next == wdog_limit)
                wdog_timeout <= 1'b1;                                // held until cleared
        end
    end

    // -------------------- read-back
    always_comb begin
        main_hit   = 1'b1;
        main_rdata = '0;
        case (reg_raddr)
            board_bus_pkg::reg_status:
                main_rdata = {wdog_timeout,
                              {(board_bus_pkg::data_w-board_bus_pkg::board_id_w-1){1'b0}},
                              board_id};
            board_bus_pkg::reg_wdog:
                main_rdata = {{(board_bus_pkg::data_w-board_bus_pkg::wdog_period_w){1'b0}},
                              wdog_period};
            board_bus_pkg::reg_ipaddr:
                main_rdata = ip_address;
            default:
                main_hit = 1'b0;                                     // served by board side
        endcase
    end

endmodule

/* verilog/read_data_mux.sv */
// result stage of the hub: picks the read data for the decoded region
`timescale 1ns/1ps

module read_data_mux (
    input  logic [board_bus_pkg::region_count-1:0]  region_sel,   // one-hot from decode
    input  logic                                    main_hit,
    input  logic [board_bus_pkg::data_w-1:0]        main_rdata,
    input  logic [board_bus_pkg::data_w-1:0]        hub_rdata,
    input  logic [board_bus_pkg::data_w-1:0]        prom_rdata,
    input  logic [board_bus_pkg::data_w-1:0]        fw_rdata,
    input  logic [board_bus_pkg::data_w-1:0]        ext_rdata,
    output logic [board_bus_pkg::data_w-1:0]        reg_rdata
);

    always_comb begin
        if (region_sel[board_bus_pkg::sel_hub])
            reg_rdata = hub_rdata;
        else if (region_sel[board_bus_pkg::sel_prom])
            reg_rdata = prom_rdata;
        else if (region_sel[board_bus_pkg::sel_fw])
            reg_rdata = fw_rdata;
        else if (region_sel[board_bus_pkg::sel_main] && main_hit)
            reg_rdata = main_rdata;                     // own board registers
        else
            reg_rdata = ext_rdata;                      // ext region or unowned main index
    end

endmodule

/* verilog/board_bus_hub.sv */
// top of the register-bus hub: arbitration, decode, board registers and read-data return
`timescale 1ns/1ps

module board_bus_hub (
    input  logic                                      sysclk,
    input  logic                                      rst_n,
    input  logic [board_bus_pkg::board_id_w-1:0]      board_id,
    input  logic                                      wdog_clear,
    // block-write engine
    input  logic                                      bw_write_en,
    input  logic                                      bw_reg_wen,
    input  logic                                      bw_blk_wen,
    input  logic                                      bw_blk_wstart,
    input  logic [board_bus_pkg::bw_addr_w-1:0]       bw_reg_waddr,
    input  logic [board_bus_pkg::data_w-1:0]          bw_reg_wdata,
    // ethernet host
    input  logic                                      eth_write_en,
    input  logic                                      eth_reg_wen,
    input  logic                                      eth_blk_wen,
    input  logic                                      eth_blk_wstart,
    input  logic [board_bus_pkg::addr_w-1:0]          eth_reg_waddr,
    input  logic [board_bus_pkg::data_w-1:0]          eth_reg_wdata,
    input  logic                                      eth_req_read_bus,
    input  logic [board_bus_pkg::addr_w-1:0]          eth_reg_raddr,
    input  logic                                      eth_rt_wen,
    input  logic [board_bus_pkg::rt_addr_w-1:0]       eth_rt_waddr,
    input  logic [board_bus_pkg::data_w-1:0]          eth_rt_wdata,
    input  logic                                      eth_sample_start,
    input  logic                                      eth_sample_read,
    input  logic [board_bus_pkg::sample_addr_w-1:0]   eth_sample_raddr,
    // firewire host
    input  logic                                      fw_reg_wen,
    input  logic                                      fw_blk_wen,
    input  logic                                      fw_blk_wstart,
    input  logic [board_bus_pkg::addr_w-1:0]          fw_reg_waddr,
    input  logic [board_bus_pkg::data_w-1:0]          fw_reg_wdata,
    input  logic [board_bus_pkg::addr_w-1:0]          fw_reg_raddr,
    input  logic                                      fw_rt_wen,
    input  logic [board_bus_pkg::rt_addr_w-1:0]       fw_rt_waddr,
    input  logic [board_bus_pkg::data_w-1:0]          fw_rt_wdata,
    input  logic                                      fw_sample_start,
    input  logic                                      fw_sample_read,
    input  logic [board_bus_pkg::sample_addr_w-1:0]   fw_sample_raddr,
    input  logic                                      sample_busy,
    // read data from regions outside the hub
    input  logic [board_bus_pkg::data_w-1:0]          hub_rdata,
    input  logic [board_bus_pkg::data_w-1:0]          prom_rdata,
    input  logic [board_bus_pkg::data_w-1:0]          fw_rdata,
    input  logic [board_bus_pkg::data_w-1:0]          ext_rdata,
    // shared board bus
    output logic                                      reg_wen,
    output logic                                      blk_wen,
    output logic                                      blk_wstart,
    output logic [board_bus_pkg::addr_w-1:0]          reg_waddr,
    output logic [board_bus_pkg::data_w-1:0]          reg_wdata,
    output logic [board_bus_pkg::addr_w-1:0]          reg_raddr,
    output logic [board_bus_pkg::data_w-1:0]          reg_rdata,
    output logic                                      rt_wen,
    output logic [board_bus_pkg::rt_addr_w-1:0]       rt_waddr,
    output logic [board_bus_pkg::data_w-1:0]          rt_wdata,
    output logic                                      sample_start,
    output logic                                      sample_read,
    output logic [board_bus_pkg::sample_addr_w-1:0]   sample_raddr,
    output logic                                      wdog_timeout
);

    // --------------------
    // local wires between stages
    logic [board_bus_pkg::region_count-1:0] region_sel;   // decode to result
    logic                                   ip_wen;
    logic                                   wdog_wen;
    logic [board_bus_pkg::data_w-1:0]       main_rdata;   // board regs to result
    logic                                   main_hit;

    host_bus_arbiter arb0 (.*);   // every arbiter port shares its name with a top port

    reg_addr_decode dec0 (
        .reg_raddr  (reg_raddr),
        .reg_waddr  (reg_waddr),
        .reg_wen    (reg_wen),
        .region_sel (region_sel),
        .ip_wen     (ip_wen),
        .wdog_wen   (wdog_wen)
    );

    board_regs regs0 (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .board_id     (board_id),
        .reg_raddr    (reg_raddr[board_bus_pkg::reg_idx_w-1:0]),   // index only
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .ip_wen       (ip_wen),
        .wdog_wen     (wdog_wen),
        .wdog_clear   (wdog_clear),
        .main_rdata   (main_rdata),
        .main_hit     (main_hit),
        .wdog_timeout (wdog_timeout),
        .ip_address   ()              // consumer is the ethernet block, outside this hub
    );

    read_data_mux rmux0 (
        .region_sel (region_sel),
        .main_hit   (main_hit),
        .main_rdata (main_rdata),
        .hub_rdata  (hub_rdata),
        .prom_rdata (prom_rdata),
        .fw_rdata   (fw_rdata),
        .ext_rdata  (ext_rdata),
        .reg_rdata  (reg_rdata)
    );

endmodule

/* dv/board_bus_hub_tb.sv */
// testbench for the board bus hub: drives the three host ports, checks routing, reads and watchdog
`timescale 1ns/1ps

module board_bus_hub_tb;

    // -------------------- DUT inputs
    logic        sysclk;
    logic        rst_n;
    logic [3:0]  board_id;
    logic        wdog_clear;
    logic        bw_write_en, bw_reg_wen, bw_blk_wen, bw_blk_wstart;
    logic [7:0]  bw_reg_waddr;
    logic [31:0] bw_reg_wdata;
    logic        eth_write_en, eth_reg_wen, eth_blk_wen, eth_blk_wstart, eth_req_read_bus;
    logic [15:0] eth_reg_waddr, eth_reg_raddr;
    logic [31:0] eth_reg_wdata, eth_rt_wdata;
    logic        eth_rt_wen, eth_sample_start, eth_sample_read;
    logic [3:0]  eth_rt_waddr;
    logic [5:0]  eth_sample_raddr;
    logic        fw_reg_wen, fw_blk_wen, fw_blk_wstart;
    logic [15:0] fw_reg_waddr, fw_reg_raddr;
    logic [31:0] fw_reg_wdata, fw_rt_wdata;
    logic        fw_rt_wen, fw_sample_start, fw_sample_read, sample_busy;
    logic [3:0]  fw_rt_waddr;
    logic [5:0]  fw_sample_raddr;
    logic [31:0] hub_rdata, prom_rdata, fw_rdata, ext_rdata;

    // -------------------- DUT outputs
    logic        reg_wen, blk_wen, blk_wstart, rt_wen, sample_start, sample_read, wdog_timeout;
    logic [15:0] reg_waddr, reg_raddr;
    logic [31:0] reg_wdata, reg_rdata, rt_wdata;
    logic [3:0]  rt_waddr;
    logic [5:0]  sample_raddr;

    // -------------------- reference state
    integer      seed = 32'h8613;
    logic [31:0] ip_model;                 // expected IP register
    logic [15:0] period_model;             // expected watchdog period
    logic [2:0]  exp_ctl;                  // wen, blk_wen, blk_wstart
    logic [15:0] exp_addr;
    logic [31:0] exp_data;
    int          limit;                    // period times tick cycles

    board_bus_hub dut0 (.*);

    initial sysclk = 1'b0;
    always #50 sysclk = ~sysclk;           // 100 ns

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
        else stop_with_failure($sformatf("error %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic next_cycle();
        @(posedge sysclk);
        #5;                                // drive point after the edge
    endtask

    task automatic idle_inputs();
        {bw_write_en, bw_reg_wen, bw_blk_wen, bw_blk_wstart, bw_reg_waddr, bw_reg_wdata} = '0;
        {eth_write_en, eth_reg_wen, eth_blk_wen, eth_blk_wstart, eth_reg_waddr,
         eth_reg_wdata, eth_req_read_bus, eth_reg_raddr} = '0;
        {eth_rt_wen, eth_rt_waddr, eth_rt_wdata, eth_sample_start, eth_sample_read,
         eth_sample_raddr} = '0;
        {fw_reg_wen, fw_blk_wen, fw_blk_wstart, fw_reg_waddr, fw_reg_wdata, fw_reg_raddr} = '0;
        {fw_rt_wen, fw_rt_waddr, fw_rt_wdata, fw_sample_start, fw_sample_read,
         fw_sample_raddr, sample_busy, wdog_clear} = '0;
        {hub_rdata, prom_rdata, fw_rdata, ext_rdata} = '0;
    endtask

    // ethernet write, accepted on the next edge
    task automatic write_eth(input logic [15:0] addr, input logic [31:0] data);
        eth_write_en  = 1'b1;
        eth_reg_wen   = 1'b1;
        eth_reg_waddr = addr;
        eth_reg_wdata = data;
        next_cycle();
        eth_write_en  = 1'b0;
        eth_reg_wen   = 1'b0;
    endtask

    task automatic check_read(input logic [15:0] addr, input logic [31:0] exp);
        eth_req_read_bus = 1'b1;
        eth_reg_raddr    = addr;
        #20;                               // combinational read settles
        expect_equal("reg_rdata", reg_rdata, exp);
    endtask

    // counts edges until the flag rises, bounded at min_cycles + 2
    task automatic wait_wdog(input int min_cycles);
        int n;
        n = 0;
        while (!wdog_timeout && n < min_cycles + 2) begin
            next_cycle();
            n++;
        end
        if (!wdog_timeout)
            stop_with_failure($sformatf("watchdog never timed out within %0d cycles",
                                        min_cycles + 2));
        assert (n >= min_cycles)
        else stop_with_failure($sformatf("error wdog_timeout: rose after %h cycles, expected %h",
                                         n, min_cycles));
    endtask

    // kind 0..2 hub/prom/fw, 3 owned main index, 4 unowned index, 5..6 ext
    function automatic logic [15:0] make_read_addr(input int kind);
        logic [11:0] low;
        logic [3:0]  idx;
        low = 12'($random(seed));
        idx = ({$random(seed)} % 3 == 0) ? 4'd0 : (low[0] ? 4'd3 : 4'd11);
        case (kind)
            0:       return {board_bus_pkg::addr_hub, low};
            1:       return {board_bus_pkg::addr_prom, low};
            2:       return {board_bus_pkg::addr_fw, low};
            3:       return {4'd0, low[11:8], 4'd0, idx};
            4:       return {4'd0, low[11:8], 4'd0, 4'd5 + {2'd0, low[1:0]}};
            5:       return {4'd0, low[11:8], low[7:4] | 4'h1, low[3:0]};   // outside index block
            default: return {4'd7 + {1'b0, low[2:0]}, low};
        endcase
    endfunction

    function automatic logic [31:0] expected_rdata(input logic [15:0] addr, input logic flag);
        if (addr[15:12] == board_bus_pkg::addr_hub)
            return hub_rdata;
        if (addr[15:12] == board_bus_pkg::addr_prom)
            return prom_rdata;
        if (addr[15:12] == board_bus_pkg::addr_fw)
            return fw_rdata;
        if (addr[15:12] == board_bus_pkg::addr_main && addr[7:4] == 4'd0) begin
            if (addr[3:0] == 4'd0)
                return {flag, 27'd0, board_id};                // status
            if (addr[3:0] == 4'd3)
                return {16'd0, period_model};
            if (addr[3:0] == 4'd11)
                return ip_model;
        end
        return ext_rdata;
    endfunction

    initial begin
        idle_inputs();
        rst_n        = 1'b0;
        board_id     = 4'($random(seed));
        ip_model     = board_bus_pkg::ip_reset_value;
        period_model = '0;
        repeat (10) @(posedge sysclk);
        #5;
        rst_n = 1'b1;
        next_cycle();

        // -------------------- idle after reset
        expect_equal("reg_wen", reg_wen, 0);
        expect_equal("blk_wen", blk_wen, 0);
        expect_equal("blk_wstart", blk_wstart, 0);
        expect_equal("rt_wen", rt_wen, 0);
        expect_equal("sample_start", sample_start, 0);
        expect_equal("wdog_timeout", wdog_timeout, 0);
        check_read(16'h000b, board_bus_pkg::ip_reset_value);

        // -------------------- write priority
        for (int i = 0; i < 24; i++) begin
            next_cycle();
            {bw_write_en, bw_reg_wen, bw_blk_wen, bw_blk_wstart, bw_reg_waddr, bw_reg_wdata}
                = {12'($random(seed)), 32'($random(seed))};
            {eth_write_en, eth_reg_wen, eth_blk_wen, eth_blk_wstart, eth_reg_waddr,
             eth_reg_wdata} = {20'($random(seed)), 32'($random(seed))};
            {fw_reg_wen, fw_blk_wen, fw_blk_wstart, fw_reg_waddr, fw_reg_wdata}
                = {19'($random(seed)), 32'($random(seed))};
            bw_reg_waddr[7]   = 1'b1;          // stay off the board registers
            eth_reg_waddr[15] = 1'b1;
            fw_reg_waddr[15]  = 1'b1;
            #20;
            if (bw_write_en) begin
                exp_ctl  = {bw_reg_wen, bw_blk_wen, bw_blk_wstart};
                exp_addr = {8'h00, bw_reg_waddr};
                exp_data = bw_reg_wdata;
            end else if (eth_write_en) begin
                exp_ctl  = {eth_reg_wen, eth_blk_wen, eth_blk_wstart};
                exp_addr = eth_reg_waddr;
                exp_data = eth_reg_wdata;
            end else begin
                exp_ctl  = {fw_reg_wen, fw_blk_wen, fw_blk_wstart};
                exp_addr = fw_reg_waddr;
                exp_data = fw_reg_wdata;
            end
            expect_equal("reg_wen", reg_wen, exp_ctl[2]);
            expect_equal("blk_wen", blk_wen, exp_ctl[1]);
            expect_equal("blk_wstart", blk_wstart, exp_ctl[0]);
            expect_equal("reg_waddr", reg_waddr, exp_addr);
            expect_equal("reg_wdata", reg_wdata, exp_data);
        end
        idle_inputs();

        // -------------------- read routing over all regions
        for (int i = 0; i < 40; i++) begin
            next_cycle();
            hub_rdata        = $random(seed);
            prom_rdata       = $random(seed);
            fw_rdata         = $random(seed);
            ext_rdata        = $random(seed);
            eth_req_read_bus = 1'($random(seed));
            eth_reg_raddr    = make_read_addr({$random(seed)} % 7);
            fw_reg_raddr     = make_read_addr({$random(seed)} % 7);
            #20;
            exp_addr = eth_req_read_bus ? eth_reg_raddr : fw_reg_raddr;
            expect_equal("reg_raddr", reg_raddr, exp_addr);
            expect_equal("reg_rdata", reg_rdata, expected_rdata(exp_addr, 1'b0));
        end

        // -------------------- IP address and status
        next_cycle();
        ip_model = $random(seed);
        write_eth(16'h000b, ip_model);
        check_read(16'h000b, ip_model);
        check_read(16'h0000, expected_rdata(16'h0000, 1'b0));

        // -------------------- watchdog
        limit        = 16 * (2 + ({$random(seed)} % 3));
        period_model = 16'(limit / 16);
        write_eth(16'h0003, {16'd0, period_model});
        check_read(16'h0003, {16'd0, period_model});
        wait_wdog(limit);
        check_read(16'h0000, expected_rdata(16'h0000, 1'b1));   // flag in bit 31
        wdog_clear = 1'b1;
        next_cycle();
        wdog_clear = 1'b0;
        #20;
        expect_equal("wdog_timeout", wdog_timeout, 0);
        repeat (limit / 2) next_cycle();
        expect_equal("wdog_timeout", wdog_timeout, 0);
        ip_model     = $random(seed);
        fw_reg_wen   = 1'b1;               // firewire write kicks the counter
        fw_reg_waddr = 16'h000b;
        fw_reg_wdata = ip_model;
        next_cycle();
        fw_reg_wen = 1'b0;
        wait_wdog(limit);
        check_read(16'h000b, ip_model);
        period_model = '0;
        write_eth(16'h0003, 32'd0);        // disables and drops the flag
        for (int n = 0; n < limit + 4; n++) begin
            expect_equal("wdog_timeout", wdog_timeout, 0);
            next_cycle();
        end

        // -------------------- real-time port and sampling
        for (int i = 0; i < 24; i++) begin
            next_cycle();
            {eth_rt_wen, eth_rt_waddr, eth_rt_wdata, eth_sample_start, eth_sample_read,
             eth_sample_raddr} = {13'($random(seed)), 32'($random(seed))};
            {fw_rt_wen, fw_rt_waddr, fw_rt_wdata, fw_sample_start, fw_sample_read,
             fw_sample_raddr} = {13'($random(seed)), 32'($random(seed))};
            sample_busy = 1'($random(seed));
            #20;
            expect_equal("rt_wen", rt_wen, eth_rt_wen ? 1'b1 : fw_rt_wen);
            expect_equal("rt_waddr", rt_waddr, eth_rt_wen ? eth_rt_waddr : fw_rt_waddr);
            expect_equal("rt_wdata", rt_wdata, eth_rt_wen ? eth_rt_wdata : fw_rt_wdata);
            expect_equal("sample_start", sample_start,
                         (eth_sample_start | fw_sample_start) & ~sample_busy);
            expect_equal("sample_read", sample_read, eth_sample_read | fw_sample_read);
            expect_equal("sample_raddr", sample_raddr,
                         eth_sample_read ? eth_sample_raddr : fw_sample_raddr);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* board_bus_hub.f */
verilog/board_bus_pkg.sv
verilog/host_bus_arbiter.sv
verilog/reg_addr_decode.sv
verilog/board_regs.sv
verilog/read_data_mux.sv
verilog/board_bus_hub.sv
dv/board_bus_hub_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f board_bus_hub.f \
    --top-module board_bus_hub_tb -o board_bus_hub_sim

out=$(./obj_dir/board_bus_hub_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
